//--- hdl/arp.sv
// ============================================================
// ARP engine for IPv4 on parsed frame fields
// source MAC and IP of outgoing frames are local_mac, local_ip
// timer parameters count ticks of tick_divide clock cycles
// ============================================================
`timescale 1ns/10ps
`default_nettype none

module arp #(
    parameter int tick_divide = arp_pkg::default_tick_divide,
    parameter int retry_count = arp_pkg::default_retry_count,
    parameter int retry_interval = arp_pkg::default_retry_interval,
    parameter int timeout = arp_pkg::default_timeout
) (
    input  wire                             clk,
    input  wire                             rst,
    input  wire                             rx_valid,
    output logic                            rx_ready,
    input  wire  [arp_pkg::mac_width-1:0]   rx_eth_src_mac,
    input  wire  [arp_pkg::oper_width-1:0]  rx_arp_oper,
    input  wire  [arp_pkg::mac_width-1:0]   rx_arp_sha,
    input  wire  [arp_pkg::ip_width-1:0]    rx_arp_spa,
    input  wire  [arp_pkg::mac_width-1:0]   rx_arp_tha,
    input  wire  [arp_pkg::ip_width-1:0]    rx_arp_tpa,
    output logic                            tx_valid,
    input  wire                             tx_ready,
    output logic [arp_pkg::mac_width-1:0]   tx_eth_dest_mac,
    output logic [arp_pkg::oper_width-1:0]  tx_arp_oper,
    output logic [arp_pkg::mac_width-1:0]   tx_arp_tha,
    output logic [arp_pkg::ip_width-1:0]    tx_arp_tpa,
    input  wire                             arp_request_valid,
    output logic                            arp_request_ready,
    input  wire  [arp_pkg::ip_width-1:0]    arp_request_ip,
    output logic                            arp_response_valid,
    input  wire                             arp_response_ready,
    output logic                            arp_response_error,
    output logic [arp_pkg::mac_width-1:0]   arp_response_mac,
    input  wire  [arp_pkg::mac_width-1:0]   local_mac,
    input  wire  [arp_pkg::ip_width-1:0]    local_ip,
    input  wire  [arp_pkg::ip_width-1:0]    gateway_ip,
    input  wire  [arp_pkg::ip_width-1:0]    subnet_mask,
    input  wire                             clear_cache
);

    // cache query and write
    logic                           query_valid;
    logic [arp_pkg::ip_width-1:0]   query_ip;
    logic                           response_valid;
    logic                           response_error;
    logic [arp_pkg::mac_width-1:0]  response_mac;
    logic                           write_valid;
    logic [arp_pkg::ip_width-1:0]   write_ip;
    logic [arp_pkg::mac_width-1:0]  write_mac;

    // request frames and retry timer
    logic                           req_send;
    logic [arp_pkg::ip_width-1:0]   req_tpa;
    logic                           timer_load_interval;
    logic                           timer_load_timeout;
    logic                           timer_run;
    logic                           timer_expired;

    arp_cache cache_inst (.*);

    arp_retry_timer #(
        .tick_divide(tick_divide),
        .retry_interval(retry_interval),
        .timeout(timeout)
    ) timer_inst (
        .clk(clk),
        .rst(rst),
        .load_interval(timer_load_interval),
        .load_timeout(timer_load_timeout),
        .run(timer_run),
        .expired(timer_expired)
    );

    arp_resolver #(
        .retry_count(retry_count)
    ) resolver_inst (.*);

    arp_frame_handler frame_inst (.*);

endmodule

`default_nettype wire

//--- hdl/arp_cache.sv
// ============================================================
// direct-mapped IP to MAC cache, indexed by the low IP bits
// query answers one cycle later, a write replaces the entry
// a write and a query in the same cycle see the old entry
// ============================================================
`timescale 1ns/10ps
`default_nettype none

module arp_cache (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            query_valid,
    input  wire  [arp_pkg::ip_width-1:0]   query_ip,
    input  wire                            write_valid,
    input  wire  [arp_pkg::ip_width-1:0]   write_ip,
    input  wire  [arp_pkg::mac_width-1:0]  write_mac,
    input  wire                            clear_cache,
    output logic                           response_valid,
    output logic                           response_error,
    output logic [arp_pkg::mac_width-1:0]  response_mac
);

    localparam int entries = 2 ** arp_pkg::cache_addr_width;

    logic [entries-1:0]              valid_bits;
    logic [arp_pkg::ip_width-1:0]    tag_mem [entries];
    logic [arp_pkg::mac_width-1:0]   mac_mem [entries];
    logic [arp_pkg::cache_addr_width-1:0] query_idx;
    logic [arp_pkg::cache_addr_width-1:0] write_idx;

    assign query_idx = query_ip[arp_pkg::cache_addr_width-1:0];
    assign write_idx = write_ip[arp_pkg::cache_addr_width-1:0];

    // clear wins over a write in the same cycle
    always_ff @(posedge clk) begin
        if (rst || clear_cache) begin
            valid_bits <= '0;
        end else if (write_valid) begin
            valid_bits[write_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (write_valid) begin
            tag_mem[write_idx] <= write_ip;
            mac_mem[write_idx] <= write_mac;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            response_valid <= 1'b0;
        end else begin
            response_valid <= query_valid;
        end
    end

    // miss on an empty entry or a different tag
    always_ff @(posedge clk) begin
        response_error <= !valid_bits[query_idx] || (tag_mem[query_idx] != query_ip);
        response_mac <= mac_mem[query_idx];
    end

endmodule

`default_nettype wire

//--- hdl/arp_frame_handler.sv
// ============================================================
// incoming frames are taken as parsed fields, all assumed ARP
// one outgoing frame register, a new load overwrites it
// ============================================================
`timescale 1ns/10ps
`default_nettype none

module arp_frame_handler (
    input  wire                             clk,
    input  wire                             rst,
    input  wire                             rx_valid,
    output logic                            rx_ready,
    input  wire  [arp_pkg::mac_width-1:0]   rx_eth_src_mac,
    input  wire  [arp_pkg::oper_width-1:0]  rx_arp_oper,
    input  wire  [arp_pkg::mac_width-1:0]   rx_arp_sha,
    input  wire  [arp_pkg::ip_width-1:0]    rx_arp_spa,
    input  wire  [arp_pkg::mac_width-1:0]   rx_arp_tha,
    input  wire  [arp_pkg::ip_width-1:0]    rx_arp_tpa,
    output logic                            tx_valid,
    input  wire                             tx_ready,
    output logic [arp_pkg::mac_width-1:0]   tx_eth_dest_mac,
    output logic [arp_pkg::oper_width-1:0]  tx_arp_oper,
    output logic [arp_pkg::mac_width-1:0]   tx_arp_tha,
    output logic [arp_pkg::ip_width-1:0]    tx_arp_tpa,
    input  wire  [arp_pkg::mac_width-1:0]   local_mac,
    input  wire  [arp_pkg::ip_width-1:0]    local_ip,
    input  wire                             req_send,
    input  wire  [arp_pkg::ip_width-1:0]    req_tpa,
    output logic                            write_valid,
    output logic [arp_pkg::ip_width-1:0]    write_ip,
    output logic [arp_pkg::mac_width-1:0]   write_mac
);

    logic accept;
    logic arp_match;
    logic inarp_match;
    logic reply;

    // a request frame from the resolver takes the slot this cycle
    assign rx_ready = tx_ready && !req_send;
    assign accept = rx_valid && rx_ready;

    assign arp_match = (rx_arp_oper == arp_pkg::oper_request) && (rx_arp_tpa == local_ip);
    assign inarp_match = (rx_arp_oper == arp_pkg::oper_inarp_request) &&
                         (rx_arp_tha == local_mac);
    assign reply = accept && (arp_match || inarp_match);

    always_ff @(posedge clk) begin
        if (rst) begin
            tx_valid <= 1'b0;
            write_valid <= 1'b0;
        end else begin
            write_valid <= accept;
            if (req_send || reply) begin
                tx_valid <= 1'b1;
            end else if (tx_ready) begin
                tx_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            write_ip <= rx_arp_spa;
            write_mac <= rx_arp_sha;
        end
        if (req_send) begin
            tx_eth_dest_mac <= arp_pkg::mac_broadcast;
            tx_arp_oper <= arp_pkg::oper_request;
            tx_arp_tha <= arp_pkg::mac_zero;
            tx_arp_tpa <= req_tpa;
        end else if (reply) begin
            // reply goes back to the sender
            tx_eth_dest_mac <= rx_eth_src_mac;
            tx_arp_oper <= inarp_match ? arp_pkg::oper_inarp_reply : arp_pkg::oper_reply;
            tx_arp_tha <= rx_arp_sha;
            tx_arp_tpa <= rx_arp_spa;
        end
    end

endmodule

`default_nettype wire

//--- hdl/arp_pkg.sv
// ============================================================
// shared widths, opcodes and default timing of the ARP engine
// timing defaults assume a 125 MHz clock and 1 ms ticks
// ============================================================
`default_nettype none

package arp_pkg;

    // address and field widths
    localparam int mac_width = 48;
    localparam int ip_width = 32;
    localparam int oper_width = 16;

    // ARP and InARP opcodes
    localparam logic [oper_width-1:0] oper_request = 16'd1;
    localparam logic [oper_width-1:0] oper_reply = 16'd2;
    localparam logic [oper_width-1:0] oper_inarp_request = 16'd8;
    localparam logic [oper_width-1:0] oper_inarp_reply = 16'd9;

    localparam logic [mac_width-1:0] mac_broadcast = {mac_width{1'b1}};
    localparam logic [mac_width-1:0] mac_zero = '0;

    // 16 cache entries
    localparam int cache_addr_width = 4;

    // retry timing, interval and timeout in ticks
    localparam int default_tick_divide = 125000;
    localparam int default_retry_count = 4;
    localparam int default_retry_interval = 2000;
    localparam int default_timeout = 30000;
    localparam int timer_width = 16;

endpackage

`default_nettype wire

//--- hdl/arp_resolver.sv
// ============================================================
// lookup request FSM: classify, query the cache, retry on miss
// subnet test compares the address against gateway_ip
// request and timer strobes are decoded from state, one cycle
// ============================================================
`timescale 1ns/10ps
`default_nettype none

module arp_resolver #(
    parameter int retry_count = arp_pkg::default_retry_count
) (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            arp_request_valid,
    output logic                           arp_request_ready,
    input  wire  [arp_pkg::ip_width-1:0]   arp_request_ip,
    output logic                           arp_response_valid,
    input  wire                            arp_response_ready,
    output logic                           arp_response_error,
    output logic [arp_pkg::mac_width-1:0]  arp_response_mac,
    input  wire  [arp_pkg::ip_width-1:0]   gateway_ip,
    input  wire  [arp_pkg::ip_width-1:0]   subnet_mask,
    output logic                           query_valid,
    output logic [arp_pkg::ip_width-1:0]   query_ip,
    input  wire                            response_valid,
    input  wire                            response_error,
    input  wire  [arp_pkg::mac_width-1:0]  response_mac,
    output logic                           req_send,
    output logic [arp_pkg::ip_width-1:0]   req_tpa,
    output logic                           timer_load_interval,
    output logic                           timer_load_timeout,
    output logic                           timer_run,
    input  wire                            timer_expired
);

    localparam int retry_width = $clog2(retry_count + 1);

    typedef enum logic [1:0] {
        state_idle,
        state_querying,
        state_resolving
    } state_t;

    state_t                         state, state_next;
    logic [arp_pkg::ip_width-1:0]   lookup_ip, lookup_ip_next;
    logic [retry_width-1:0]         retries, retries_next;
    logic                           query_valid_next;
    logic                           resp_valid_next;
    logic                           resp_error_next;
    logic [arp_pkg::mac_width-1:0]  resp_mac_next;
    logic                           in_subnet;
    logic                           is_broadcast;

    // no bits differ from the gateway where the mask is set
    assign in_subnet = ((arp_request_ip ^ gateway_ip) & subnet_mask) == '0;
    assign is_broadcast = (arp_request_ip == '1) ||
                          (in_subnet && ((arp_request_ip | subnet_mask) == '1));

    assign query_ip = lookup_ip;
    assign req_tpa = lookup_ip;
    assign timer_run = (state == state_resolving);

    always_comb begin
        state_next = state;
        lookup_ip_next = lookup_ip;
        retries_next = retries;
        query_valid_next = query_valid;
        resp_valid_next = arp_response_valid && !arp_response_ready;
        resp_error_next = arp_response_error;
        resp_mac_next = arp_response_mac;
        req_send = 1'b0;
        timer_load_interval = 1'b0;
        timer_load_timeout = 1'b0;
        case (state)
            state_idle: begin
                if (arp_request_valid && arp_request_ready) begin
                    if (is_broadcast) begin
                        resp_valid_next = 1'b1;
                        resp_error_next = 1'b0;
                        resp_mac_next = arp_pkg::mac_broadcast;
                    end else begin
                        state_next = state_querying;
                        query_valid_next = 1'b1;
                        lookup_ip_next = in_subnet ? arp_request_ip : gateway_ip;
                    end
                end
            end
            state_querying: begin
                if (response_valid && response_error) begin
                    // first miss sends the first request frame
                    state_next = state_resolving;
                    req_send = 1'b1;
                    retries_next = retry_width'(retry_count - 1);
                    timer_load_timeout = (retry_count == 1);
                    timer_load_interval = (retry_count != 1);
                end else if (response_valid) begin
                    state_next = state_idle;
                    query_valid_next = 1'b0;
                    resp_valid_next = 1'b1;
                    resp_error_next = 1'b0;
                    resp_mac_next = response_mac;
                end
            end
            default: begin
                if (response_valid && !response_error) begin
                    state_next = state_idle;
                    query_valid_next = 1'b0;
                    resp_valid_next = 1'b1;
                    resp_error_next = 1'b0;
                    resp_mac_next = response_mac;
                end else if (timer_expired && retries != '0) begin
                    // the last frame waits for the long timeout
                    req_send = 1'b1;
                    retries_next = retries - 1'b1;
                    timer_load_timeout = (retries == 1);
                    timer_load_interval = (retries != 1);
                end else if (timer_expired) begin
                    state_next = state_idle;
                    query_valid_next = 1'b0;
                    resp_valid_next = 1'b1;
                    resp_error_next = 1'b1;
                    resp_mac_next = arp_pkg::mac_zero;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= state_idle;
            retries <= '0;
            query_valid <= 1'b0;
            arp_response_valid <= 1'b0;
            arp_request_ready <= 1'b0;
        end else begin
            state <= state_next;
            retries <= retries_next;
            query_valid <= query_valid_next;
            arp_response_valid <= resp_valid_next;
            arp_request_ready <= (state_next == state_idle) && !resp_valid_next;
        end
    end

    always_ff @(posedge clk) begin
        lookup_ip <= lookup_ip_next;
        arp_response_error <= resp_error_next;
        arp_response_mac <= resp_mac_next;
    end

endmodule

`default_nettype wire

//--- hdl/arp_retry_timer.sv
// ============================================================
// two-stage retry timer, prescaler ticks and a tick countdown
// expired is high while the count is zero, also after reset
// ============================================================
`timescale 1ns/10ps
`default_nettype none

module arp_retry_timer #(
    parameter int tick_divide = arp_pkg::default_tick_divide,
    parameter int retry_interval = arp_pkg::default_retry_interval,
    parameter int timeout = arp_pkg::default_timeout
) (
    input  wire  clk,
    input  wire  rst,
    input  wire  load_interval,
    input  wire  load_timeout,
    input  wire  run,
    output logic expired
);

    localparam int presc_width = $clog2(tick_divide + 1);

    logic [presc_width-1:0]          presc;
    logic [arp_pkg::timer_width-1:0] count;
    logic                            tick;

    assign tick = run && (presc == presc_width'(tick_divide - 1));
    assign expired = (count == '0);

    // a load restarts the prescaler so the first tick is a full period
    always_ff @(posedge clk) begin
        if (rst) begin
            presc <= '0;
            count <= '0;
        end else if (load_timeout) begin
            presc <= '0;
            count <= arp_pkg::timer_width'(timeout);
        end else if (load_interval) begin
            presc <= '0;
            count <= arp_pkg::timer_width'(retry_interval);
        end else if (run) begin
            presc <= tick ? '0 : presc + 1'b1;
            if (tick && !expired) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- sim/arp_patterns.txt
# F src_mac oper sha spa tha tpa, then reply dest_mac oper tha tpa, or none for no frame
# L ip error mac request_frames request_tpa; S ip request_tpa; R error mac; C clear cache
F 021111111111 1 021111111111 0a000005 0 0a000002 021111111111 2 021111111111 0a000005
F 022222222222 8 022222222222 0a000007 020000000001 0 022222222222 9 022222222222 0a000007
F 023333333333 1 023333333333 0a000009 0 0a000063 none
L 0a000005 0 021111111111 0 0
L 0a000007 0 022222222222 0 0
L ffffffff 0 ffffffffffff 0 0
L 0a0000ff 0 ffffffffffff 0 0
S 08080808 0a000001
F 02aa00000001 2 02aa00000001 0a000001 020000000001 0a000002 none
R 0 02aa00000001
L 08080809 0 02aa00000001 0 0
L 0a000033 1 0 3 0a000033
C
L 0a000005 1 0 3 0a000005

//--- sim/tb_arp.sv
// ============================================================
// runs the steps of sim/arp_patterns.txt, path from project root
// tx_ready and arp_response_ready stay high, so every cycle
// with tx_valid is one frame and a response lasts one cycle
// ============================================================
`timescale 1ns/10ps
`default_nettype none

module tb_arp;

    localparam int wait_limit = 1000;

    logic        clk;
    logic        rst;
    logic        rx_valid;
    logic        rx_ready;
    logic [47:0] rx_eth_src_mac;
    logic [15:0] rx_arp_oper;
    logic [47:0] rx_arp_sha;
    logic [31:0] rx_arp_spa;
    logic [47:0] rx_arp_tha;
    logic [31:0] rx_arp_tpa;
    logic        tx_valid;
    logic        tx_ready;
    logic [47:0] tx_eth_dest_mac;
    logic [15:0] tx_arp_oper;
    logic [47:0] tx_arp_tha;
    logic [31:0] tx_arp_tpa;
    logic        arp_request_valid;
    logic        arp_request_ready;
    logic [31:0] arp_request_ip;
    logic        arp_response_valid;
    logic        arp_response_ready;
    logic        arp_response_error;
    logic [47:0] arp_response_mac;
    logic [47:0] local_mac;
    logic [31:0] local_ip;
    logic [31:0] gateway_ip;
    logic [31:0] subnet_mask;
    logic        clear_cache;

    int errors;
    int steps;
    bit timed_out;

    // outgoing frames seen since the last clear
    logic [47:0] frame_dest [$];
    logic [15:0] frame_oper [$];
    logic [47:0] frame_tha [$];
    logic [31:0] frame_tpa [$];

    arp #(
        .tick_divide(4),
        .retry_count(3),
        .retry_interval(20),
        .timeout(50)
    ) DUT (.*);

    always #4 clk = ~clk;

    always @(negedge clk) begin
        if (!rst && tx_valid) begin
            frame_dest.push_back(tx_eth_dest_mac);
            frame_oper.push_back(tx_arp_oper);
            frame_tha.push_back(tx_arp_tha);
            frame_tpa.push_back(tx_arp_tpa);
        end
    end

    task automatic report_value(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
        $display("[ERROR] %s = %h, expected %h", name, got, exp);
        errors++;
    endtask

    task automatic clear_frames();
        frame_dest.delete();
        frame_oper.delete();
        frame_tha.delete();
        frame_tpa.delete();
    endtask

    task automatic send_frame(input logic [47:0] src, input logic [15:0] oper,
                              input logic [47:0] sha, input logic [31:0] spa,
                              input logic [47:0] tha, input logic [31:0] tpa);
        int n;
        @(negedge clk);
        rx_eth_src_mac = src;
        rx_arp_oper = oper;
        rx_arp_sha = sha;
        rx_arp_spa = spa;
        rx_arp_tha = tha;
        rx_arp_tpa = tpa;
        rx_valid = 1'b1;
        n = 0;
        while (!rx_ready && n < wait_limit) begin
            @(negedge clk);
            n++;
        end
        if (!rx_ready) begin
            $display("timeout: the incoming frame was never accepted");
            timed_out = 1'b1;
        end
        // the frame transfers on the rising edge before this
        @(negedge clk);
        rx_valid = 1'b0;
    endtask

    task automatic start_lookup(input logic [31:0] ip);
        int n;
        @(negedge clk);
        arp_request_ip = ip;
        arp_request_valid = 1'b1;
        n = 0;
        while (!arp_request_ready && n < wait_limit) begin
            @(negedge clk);
            n++;
        end
        if (!arp_request_ready) begin
            $display("timeout: the lookup request was never accepted");
            timed_out = 1'b1;
        end
        @(negedge clk);
        arp_request_valid = 1'b0;
    endtask

    task automatic wait_response(input logic exp_error, input logic [47:0] exp_mac);
        int n;
        n = 0;
        while (!arp_response_valid && n < wait_limit) begin
            @(negedge clk);
            n++;
        end
        if (!arp_response_valid) begin
            $display("timeout: no lookup response arrived");
            timed_out = 1'b1;
        end else begin
            if (arp_response_error !== exp_error)
                report_value("arp_response_error", arp_response_error, exp_error);
            if (!exp_error && arp_response_mac !== exp_mac)
                report_value("arp_response_mac", arp_response_mac, exp_mac);
        end
    endtask

    task automatic wait_frames(input int count);
        int n;
        n = 0;
        while (frame_dest.size() < count && n < wait_limit) begin
            @(negedge clk);
            n++;
        end
        if (frame_dest.size() < count) begin
            $display("timeout: the expected request frame was never sent");
            timed_out = 1'b1;
        end
    endtask

    // a request frame is broadcast with opcode 1 and a zero target MAC
    task automatic check_request(input int idx, input logic [31:0] exp_tpa);
        if (frame_dest[idx] !== 48'hffff_ffff_ffff)
            report_value("tx_eth_dest_mac", frame_dest[idx], 48'hffff_ffff_ffff);
        if (frame_oper[idx] !== 16'd1)
            report_value("tx_arp_oper", frame_oper[idx], 16'd1);
        if (frame_tha[idx] !== 48'd0)
            report_value("tx_arp_tha", frame_tha[idx], 48'd0);
        if (frame_tpa[idx] !== exp_tpa)
            report_value("tx_arp_tpa", frame_tpa[idx], exp_tpa);
    endtask

    initial begin
        int fd;
        int n;
        string line;
        string rest;
        logic [7:0] kind;
        logic [47:0] f_src, f_sha, f_tha, e_dest, e_tha, e_mac;
        logic [15:0] f_oper, e_oper;
        logic [31:0] f_spa, f_tpa, e_tpa, ip, e_count;
        logic [3:0] e_err;

        clk = 1'b0;
        rst = 1'b1;
        rx_valid = 1'b0;
        rx_eth_src_mac = '0;
        rx_arp_oper = '0;
        rx_arp_sha = '0;
        rx_arp_spa = '0;
        rx_arp_tha = '0;
        rx_arp_tpa = '0;
        tx_ready = 1'b1;
        arp_request_valid = 1'b0;
        arp_request_ip = '0;
        arp_response_ready = 1'b1;
        local_mac = 48'h02_00_00_00_00_01;
        local_ip = 32'h0a_00_00_02;
        gateway_ip = 32'h0a_00_00_01;
        subnet_mask = 32'hff_ff_ff_00;
        clear_cache = 1'b0;
        errors = 0;
        steps = 0;
        timed_out = 1'b0;

        repeat (4) @(negedge clk);
        rst = 1'b0;

        fd = $fopen("sim/arp_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open the pattern file sim/arp_patterns.txt");
            errors++;
        end else begin
            while (!timed_out && $fgets(line, fd) > 0) begin
                kind = line.getc(0);
                rest = line.substr(1, line.len() - 1);
                case (kind)
                    "F": begin
                        n = $sscanf(rest, "%h %h %h %h %h %h %h %h %h %h", f_src, f_oper,
                                    f_sha, f_spa, f_tha, f_tpa, e_dest, e_oper, e_tha, e_tpa);
                        clear_frames();
                        send_frame(f_src, f_oper, f_sha, f_spa, f_tha, f_tpa);
                        @(negedge clk);
                        if (n == 10 && frame_dest.size() == 1) begin
                            if (frame_dest[0] !== e_dest)
                                report_value("tx_eth_dest_mac", frame_dest[0], e_dest);
                            if (frame_oper[0] !== e_oper)
                                report_value("tx_arp_oper", frame_oper[0], e_oper);
                            if (frame_tha[0] !== e_tha)
                                report_value("tx_arp_tha", frame_tha[0], e_tha);
                            if (frame_tpa[0] !== e_tpa)
                                report_value("tx_arp_tpa", frame_tpa[0], e_tpa);
                        end else if (frame_dest.size() != ((n == 10) ? 1 : 0)) begin
                            $display("[ERROR] wrong number of outgoing frames: %0d",
                                     frame_dest.size());
                            errors++;
                        end
                        steps++;
                    end
                    "L": begin
                        n = $sscanf(rest, "%h %h %h %h %h", ip, e_err, e_mac, e_count, e_tpa);
                        clear_frames();
                        start_lookup(ip);
                        wait_response(e_err[0], e_mac);
                        if (frame_dest.size() != e_count) begin
                            $display("[ERROR] expected %0d request frames, saw %0d",
                                     e_count, frame_dest.size());
                            errors++;
                        end
                        for (int i = 0; i < frame_dest.size(); i++) begin
                            check_request(i, e_tpa);
                        end
                        steps++;
                    end
                    "S": begin
                        n = $sscanf(rest, "%h %h", ip, e_tpa);
                        clear_frames();
                        start_lookup(ip);
                        wait_frames(1);
                        if (frame_dest.size() > 0) begin
                            check_request(0, e_tpa);
                        end
                        steps++;
                    end
                    "R": begin
                        n = $sscanf(rest, "%h %h", e_err, e_mac);
                        wait_response(e_err[0], e_mac);
                        steps++;
                    end
                    "C": begin
                        @(negedge clk);
                        clear_cache = 1'b1;
                        @(negedge clk);
                        clear_cache = 1'b0;
                        steps++;
                    end
                    "#", 8'h0a, 8'h0d: begin
                    end
                    default: begin
                        $display("unknown step in the pattern file: %s", line);
                        errors++;
                    end
                endcase
            end
            $fclose(fd);
        end

        $display("steps %0d, errors %0d, timeouts %0d", steps, errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
hdl/arp_pkg.sv
hdl/arp_cache.sv
hdl/arp_retry_timer.sv
hdl/arp_resolver.sv
hdl/arp_frame_handler.sv
hdl/arp.sv
sim/tb_arp.sv
